// File: source/emulatorPkg.sv
`default_nettype none

package emulatorPkg;

    // Addressable board positions on the I/O bus
    parameter int MAX_BOARDS = 16;

    // Input bits carried by one board
    parameter int BOARD_BITS = 8;

    // Credits the host can grant at most
    parameter int MAX_CREDITS = 15;

    // One board position on the bus
    typedef logic [$clog2(MAX_BOARDS)-1:0] boardIndexT;

    // One board's input image
    typedef logic [BOARD_BITS-1:0] boardDataT;

    // Host credit counter
    typedef logic [$clog2(MAX_CREDITS + 1)-1:0] creditT;

    // Scan sequencer states
    typedef enum logic [1:0] {
        Idle,
        Settle,
        Sample
    } scanStateT;

endpackage

`default_nettype wire

// File: source/TickDivider.sv
`timescale 1ns/100ps
`default_nettype none

module TickDivider #(
    parameter int SCAN_DIVIDE = 8
)(
    input wire Clk,
    input wire rstN,
    output logic scanTick
);

localparam int CNT_WIDTH = $clog2(SCAN_DIVIDE + 1);

logic [CNT_WIDTH-1:0] count;
logic wrap;

// Last clock of each period
assign wrap = (count == CNT_WIDTH'(SCAN_DIVIDE - 1));

always_ff @(posedge Clk) begin
    if (!rstN) begin
        count <= '0;
    end else if (wrap) begin
        count <= '0;
    end else begin
        count <= count + 1'b1;
    end
end

// Tick is registered so it lands SCAN_DIVIDE clocks after reset release
always_ff @(posedge Clk) begin
    if (!rstN) begin
        scanTick <= 1'b0;
    end else begin
        scanTick <= wrap;
    end
end

endmodule

`default_nettype wire

// File: source/IoScanSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module IoScanSequencer #(
    parameter int INSTALLED_BOARDS = 4
)(
    input wire Clk,
    input wire rstN,
    input wire scanTick,
    output emulatorPkg::boardIndexT ioAddress,
    output logic ioReadN,
    input wire emulatorPkg::boardDataT ioData,
    output emulatorPkg::boardDataT sampleData,
    output logic [INSTALLED_BOARDS-1:0] sampleStrobe
);

emulatorPkg::scanStateT state;
emulatorPkg::boardIndexT nextBoard;
logic lastBoard;

// Board counter wraps at the installed count, not at MAX_BOARDS
assign lastBoard = (nextBoard == emulatorPkg::boardIndexT'(INSTALLED_BOARDS - 1));

always_ff @(posedge Clk) begin
    if (!rstN) begin
        state <= emulatorPkg::Idle;
        nextBoard <= '0;
        ioAddress <= '0;
        ioReadN <= 1'b1;
        sampleStrobe <= '0;
    end else begin
        sampleStrobe <= '0;
        case (state)
            emulatorPkg::Idle: begin
                if (scanTick) begin
                    state <= emulatorPkg::Settle;
                    ioAddress <= nextBoard;
                    ioReadN <= 1'b0;
                    nextBoard <= lastBoard ? '0 : nextBoard + 1'b1;
                end
            end
            // First low cycle, bus data not yet valid
            emulatorPkg::Settle: begin
                state <= emulatorPkg::Sample;
            end
            emulatorPkg::Sample: begin
                state <= emulatorPkg::Idle;
                ioReadN <= 1'b1;
                sampleStrobe <= INSTALLED_BOARDS'(1) << ioAddress;
            end
            default: begin
                state <= emulatorPkg::Idle;
                ioReadN <= 1'b1;
            end
        endcase
    end
end

// Captured at the end of the second low cycle
always_ff @(posedge Clk) begin
    if (state == emulatorPkg::Sample) begin
        sampleData <= ioData;
    end
end

endmodule

`default_nettype wire

// File: source/BoardInputSlot.sv
`timescale 1ns/100ps
`default_nettype none

module BoardInputSlot (
    input wire Clk,
    input wire rstN,
    input wire strobe,
    input wire emulatorPkg::boardDataT sampleData,
    output emulatorPkg::boardDataT stableData,
    output logic changed
);

emulatorPkg::boardDataT lastSample;
logic accept;

// Two matching samples in a row that differ from the stable image
assign accept = (sampleData == lastSample) && (sampleData != stableData);

always_ff @(posedge Clk) begin
    if (!rstN) begin
        lastSample <= '0;
        stableData <= '0;
        changed <= 1'b0;
    end else begin
        changed <= 1'b0;
        if (strobe) begin
            lastSample <= sampleData;
            if (accept) begin
                stableData <= sampleData;
                changed <= 1'b1;
            end
        end
    end
end

endmodule

`default_nettype wire

// File: source/IoEventCollector.sv
`timescale 1ns/100ps
`default_nettype none

module IoEventCollector #(
    parameter int INSTALLED_BOARDS = 4,
    parameter int CREDITS = 2
)(
    input wire Clk,
    input wire rstN,
    input wire emulatorPkg::boardDataT [INSTALLED_BOARDS-1:0] stableBus,
    input wire [INSTALLED_BOARDS-1:0] changedBus,
    input wire creditReturn,
    output logic eventValid,
    output emulatorPkg::boardIndexT eventBoard,
    output emulatorPkg::boardDataT eventData
);

logic [INSTALLED_BOARDS-1:0] pending;
logic [INSTALLED_BOARDS-1:0] request;
logic [INSTALLED_BOARDS-1:0] grantMask;
emulatorPkg::boardIndexT grantIndex;
emulatorPkg::creditT credits;
emulatorPkg::creditT available;
logic issue;

// Fresh changes compete in the cycle they are flagged
assign request = pending | changedBus;

// The event now on the bus has already claimed its credit
assign available = credits - emulatorPkg::creditT'(eventValid);

assign issue = (request != '0) && (available != '0);

// Lowest pending board wins
always_comb begin
    grantIndex = '0;
    for (int i = INSTALLED_BOARDS - 1; i >= 0; i--) begin
        if (request[i]) begin
            grantIndex = emulatorPkg::boardIndexT'(i);
        end
    end
end

assign grantMask = issue ? (INSTALLED_BOARDS'(1) << grantIndex) : '0;

// A board served now reports its newest value, so its flag clears even if
// it changed again in this same cycle
always_ff @(posedge Clk) begin
    if (!rstN) begin
        pending <= '0;
        eventValid <= 1'b0;
    end else begin
        pending <= request & ~grantMask;
        eventValid <= issue;
    end
end

always_ff @(posedge Clk) begin
    if (issue) begin
        eventBoard <= grantIndex;
        eventData <= stableBus[grantIndex];
    end
end

// One credit per presented event, one back per return, capped at CREDITS
always_ff @(posedge Clk) begin
    if (!rstN) begin
        credits <= emulatorPkg::creditT'(CREDITS);
    end else if (eventValid && !creditReturn) begin
        credits <= credits - 1'b1;
    end else if (creditReturn && !eventValid) begin
        if (credits != emulatorPkg::creditT'(CREDITS)) begin
            credits <= credits + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: source/IoScanner.sv
`timescale 1ns/100ps
`default_nettype none

module IoScanner #(
    parameter int INSTALLED_BOARDS = 4,
    parameter int SCAN_DIVIDE = 8,
    parameter int CREDITS = 2
)(
    input wire Clk,
    input wire rstN,

    // Board bus
    output wire emulatorPkg::boardIndexT ioAddress,
    output wire ioReadN,
    input wire emulatorPkg::boardDataT ioData,

    // Stable image of every installed board
    output wire [INSTALLED_BOARDS*$bits(emulatorPkg::boardDataT)-1:0] inputs,

    // Host event channel
    output wire eventValid,
    output wire emulatorPkg::boardIndexT eventBoard,
    output wire emulatorPkg::boardDataT eventData,
    input wire creditReturn
);

wire scanTick;
wire emulatorPkg::boardDataT sampleData;
wire [INSTALLED_BOARDS-1:0] sampleStrobe;
wire emulatorPkg::boardDataT [INSTALLED_BOARDS-1:0] stableBus;
wire [INSTALLED_BOARDS-1:0] changedBus;

assign inputs = stableBus;

TickDivider #(
    .SCAN_DIVIDE(SCAN_DIVIDE)
) tickDivider (
    .Clk(Clk),
    .rstN(rstN),
    .scanTick(scanTick)
);

IoScanSequencer #(
    .INSTALLED_BOARDS(INSTALLED_BOARDS)
) scanSequencer (
    .Clk(Clk),
    .rstN(rstN),
    .scanTick(scanTick),
    .ioAddress(ioAddress),
    .ioReadN(ioReadN),
    .ioData(ioData),
    .sampleData(sampleData),
    .sampleStrobe(sampleStrobe)
);

// One debounce slot per installed board
for (genvar i = 0; i < INSTALLED_BOARDS; i++) begin : gSlot
    BoardInputSlot inputSlot (
        .Clk(Clk),
        .rstN(rstN),
        .strobe(sampleStrobe[i]),
        .sampleData(sampleData),
        .stableData(stableBus[i]),
        .changed(changedBus[i])
    );
end

IoEventCollector #(
    .INSTALLED_BOARDS(INSTALLED_BOARDS),
    .CREDITS(CREDITS)
) eventCollector (
    .Clk(Clk),
    .rstN(rstN),
    .stableBus(stableBus),
    .changedBus(changedBus),
    .creditReturn(creditReturn),
    .eventValid(eventValid),
    .eventBoard(eventBoard),
    .eventData(eventData)
);

endmodule

`default_nettype wire

// File: verif/IoScanner_props.sv
`timescale 1ns/100ps
`default_nettype none

module IoScanner_props #(
    parameter int INSTALLED_BOARDS = 4,
    parameter int CREDITS = 2
)(
    input wire Clk,
    input wire rstN,
    input wire emulatorPkg::boardIndexT ioAddress,
    input wire ioReadN,
    input wire [INSTALLED_BOARDS-1:0] sampleStrobe,
    input wire eventValid,
    input wire creditReturn
);

// Low cycles of the read strobe seen so far in a row
logic [1:0] lowRun;
// Credits the host has granted and not yet seen spent
int granted;

always_ff @(posedge Clk) begin
    if (!rstN) begin
        lowRun <= 2'd0;
        granted <= CREDITS;
    end else begin
        if (ioReadN) begin
            lowRun <= 2'd0;
        end else if (lowRun != 2'd3) begin
            lowRun <= lowRun + 2'd1;
        end
        granted <= granted - int'(eventValid) + int'(creditReturn);
    end
end

readLowLength: assert property (@(posedge Clk) disable iff (!rstN)
    !ioReadN |-> lowRun < 2'd2)
    else $error("ioReadN low for more than two cycles");

creditRespected: assert property (@(posedge Clk) disable iff (!rstN)
    eventValid |-> granted > 0)
    else $error("eventValid high with no credit left");

// One strobe bit right as each read ends, none otherwise
strobeOneHot: assert property (@(posedge Clk) disable iff (!rstN)
    $onehot0(sampleStrobe) && ((sampleStrobe != '0) == $rose(ioReadN)))
    else $error("sampleStrobe not a single pulse at the end of a read");

addressInRange: assert property (@(posedge Clk) disable iff (!rstN)
    int'(ioAddress) < INSTALLED_BOARDS)
    else $error("ioAddress beyond the installed boards");

endmodule

bind IoScanner IoScanner_props #(
    .INSTALLED_BOARDS(INSTALLED_BOARDS),
    .CREDITS(CREDITS)
) props (
    .Clk(Clk),
    .rstN(rstN),
    .ioAddress(ioAddress),
    .ioReadN(ioReadN),
    .sampleStrobe(sampleStrobe),
    .eventValid(eventValid),
    .creditReturn(creditReturn)
);

`default_nettype wire

// File: verif/IoScannerTb.sv
`timescale 1ns/100ps
`default_nettype none

module IoScannerTb;

localparam int INSTALLED_BOARDS = 4;
localparam int SCAN_DIVIDE = 8;
localparam int CREDITS = 2;
localparam int CLK_PERIOD = 4;
localparam int ROUND_CYCLES = INSTALLED_BOARDS * SCAN_DIVIDE;
localparam int WIDTH = INSTALLED_BOARDS * 8;
localparam int NUM_ROWS = 11;
localparam int RETURN_DELAY = 3;
localparam int DRAIN_ROUNDS = 2;

logic Clk;
logic rstN;
logic creditReturn;
emulatorPkg::boardIndexT ioAddress;
logic ioReadN;
emulatorPkg::boardDataT ioData;
logic [WIDTH-1:0] inputs;
logic eventValid;
emulatorPkg::boardIndexT eventBoard;
emulatorPkg::boardDataT eventData;

// Stimulus table, board 0 in the low byte
logic [WIDTH-1:0] rowValues [NUM_ROWS];
int rowRounds [NUM_ROWS];
logic rowCreditHold [NUM_ROWS];
logic rowGlitch [NUM_ROWS];
logic tableReady = 1'b0;

emulatorPkg::boardDataT boardValues [emulatorPkg::MAX_BOARDS];
logic [WIDTH-1:0] stableImage;
logic [15:0] lfsrState;

// Host side
emulatorPkg::boardIndexT logBoard [$];
emulatorPkg::boardDataT logData [$];
int returnDue [$];
int cycleCount;
logic creditHold;
logic returnNext;

int valueErrors;
int otherErrors;

IoScanner #(
    .INSTALLED_BOARDS(INSTALLED_BOARDS),
    .SCAN_DIVIDE(SCAN_DIVIDE),
    .CREDITS(CREDITS)
) DUT (
    .Clk(Clk),
    .rstN(rstN),
    .ioAddress(ioAddress),
    .ioReadN(ioReadN),
    .ioData(ioData),
    .inputs(inputs),
    .eventValid(eventValid),
    .eventBoard(eventBoard),
    .eventData(eventData),
    .creditReturn(creditReturn)
);

always #(CLK_PERIOD / 2) Clk = ~Clk;

// Board bus, floats while no read is in progress
assign ioData = ioReadN ? 'x : boardValues[ioAddress];

// Log events and decide credit returns away from the rising edge
always @(negedge Clk) begin
    cycleCount++;
    if (rstN && eventValid) begin
        logBoard.push_back(eventBoard);
        logData.push_back(eventData);
        returnDue.push_back(cycleCount + RETURN_DELAY);
        if (returnDue.size() > CREDITS) begin
            otherErrors++;
            $display("ERROR: event arrived although the host granted no credit");
        end
    end
    returnNext = 1'b0;
    if (!creditHold && returnDue.size() > 0 && cycleCount >= returnDue[0]) begin
        void'(returnDue.pop_front());
        returnNext = 1'b1;
    end
end

always @(posedge Clk) begin
    #1;
    creditReturn = returnNext;
end

function automatic logic [15:0] nextLfsr(input logic [15:0] state);
    // Galois form, taps 16 14 13 11
    return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
endfunction

task automatic randomValue(output logic [WIDTH-1:0] value);
    for (int i = 0; i < WIDTH; i++) begin
        value[i] = lfsrState[0];
        lfsrState = nextLfsr(lfsrState);
    end
endtask

task automatic setRow(input int idx, input logic [WIDTH-1:0] values, input int rounds,
                      input logic hold, input logic glitch);
    rowValues[idx] = values;
    rowRounds[idx] = rounds;
    rowCreditHold[idx] = hold;
    rowGlitch[idx] = glitch;
endtask

task automatic buildTable();
    logic [WIDTH-1:0] value;
    setRow(0, 32'h00000000, 3, 1'b0, 1'b0);
    setRow(1, 32'h44332211, 3, 1'b0, 1'b0);
    setRow(2, 32'h44332255, 3, 1'b0, 1'b0);
    // Glitch rows differ in every board, only the board read sees it
    setRow(3, 32'hA5A5A5A5, 3, 1'b0, 1'b1);
    setRow(4, 32'h8833CC55, 4, 1'b0, 1'b0);
    setRow(5, 32'h0F0E0D0C, 4, 1'b1, 1'b0);
    setRow(6, 32'h5A5A5A5A, 3, 1'b0, 1'b1);
    for (int r = 7; r < NUM_ROWS; r++) begin
        randomValue(value);
        setRow(r, value, 3, 1'b0, 1'b0);
    end
endtask

task automatic nextCycle();
    @(posedge Clk);
    #1;
endtask

task automatic applyValues(input logic [WIDTH-1:0] value);
    for (int b = 0; b < INSTALLED_BOARDS; b++) begin
        boardValues[b] = value[b*8 +: 8];
    end
endtask

task automatic waitReadStart();
    nextCycle();
    while (ioReadN !== 1'b1) nextCycle();
    while (ioReadN !== 1'b0) nextCycle();
endtask

task automatic waitReadEnd();
    while (ioReadN !== 1'b1) nextCycle();
endtask

task automatic checkEvents(input logic [WIDTH-1:0] target, input int expectCount);
    int bi;
    int lastBoard;
    lastBoard = -1;
    if (logBoard.size() != expectCount) begin
        otherErrors++;
        $display("ERROR: expected %0d events in this row, saw %0d", expectCount,
                 logBoard.size());
    end
    foreach (logBoard[i]) begin
        bi = int'(logBoard[i]);
        if (bi >= INSTALLED_BOARDS) begin
            valueErrors++;
            $display("FAIL eventBoard = %h, expected below %h", logBoard[i], INSTALLED_BOARDS);
        end else if (target[bi*8 +: 8] == stableImage[bi*8 +: 8]) begin
            otherErrors++;
            $display("ERROR: event for board %0d, whose value did not change", bi);
        end else if (logData[i] !== target[bi*8 +: 8]) begin
            valueErrors++;
            $display("FAIL eventData for board %0d = %h, expected %h", bi, logData[i],
                     target[bi*8 +: 8]);
        end
        if (bi <= lastBoard) begin
            otherErrors++;
            $display("ERROR: event for board %0d came after board %0d", bi, lastBoard);
        end
        lastBoard = bi;
    end
endtask

task automatic runRow(input int r);
    logic [WIDTH-1:0] target;
    int expectCount;
    int waited;
    target = rowGlitch[r] ? stableImage : rowValues[r];
    expectCount = 0;
    for (int b = 0; b < INSTALLED_BOARDS; b++) begin
        if (target[b*8 +: 8] != stableImage[b*8 +: 8]) expectCount++;
    end
    logBoard.delete();
    logData.delete();
    creditHold = rowCreditHold[r];
    if (rowGlitch[r]) begin
        // Odd value for exactly one read, then back to the old image
        waitReadStart();
        applyValues(rowValues[r]);
        waitReadEnd();
        applyValues(stableImage);
    end else begin
        // Start right after the last board is read so board 0 comes first
        waitReadStart();
        while (int'(ioAddress) != INSTALLED_BOARDS - 1) waitReadStart();
        waitReadEnd();
        applyValues(target);
    end
    repeat (rowRounds[r] * ROUND_CYCLES) nextCycle();
    if (rowCreditHold[r]) begin
        if (logBoard.size() > CREDITS) begin
            otherErrors++;
            $display("ERROR: %0d events arrived with credits withheld", logBoard.size());
        end
        creditHold = 1'b0;
    end
    waited = 0;
    while (logBoard.size() < expectCount && waited < DRAIN_ROUNDS * ROUND_CYCLES) begin
        nextCycle();
        waited++;
    end
    // Room for a stray extra event
    repeat (SCAN_DIVIDE) nextCycle();
    checkEvents(target, expectCount);
    if (inputs !== target) begin
        valueErrors++;
        $display("FAIL inputs = %h, expected %h", inputs, target);
    end
    stableImage = target;
endtask

initial begin
    Clk = 1'b0;
    rstN = 1'b0;
    creditReturn = 1'b0;
    creditHold = 1'b0;
    returnNext = 1'b0;
    cycleCount = 0;
    valueErrors = 0;
    otherErrors = 0;
    stableImage = '0;
    lfsrState = 16'd26944;
    for (int b = 0; b < emulatorPkg::MAX_BOARDS; b++) begin
        boardValues[b] = '0;
    end
    buildTable();
    tableReady = 1'b1;
    repeat (5) @(posedge Clk);
    #1;
    rstN = 1'b1;
    nextCycle();
    if (inputs !== '0) begin
        valueErrors++;
        $display("FAIL inputs = %h, expected %h", inputs, {WIDTH{1'b0}});
    end
    // Row 0 repeats the reset image, so any event there is premature
    for (int r = 0; r < NUM_ROWS; r++) begin
        runRow(r);
    end
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

initial begin : watchdog
    int totalRounds;
    totalRounds = 0;
    wait (tableReady);
    for (int r = 0; r < NUM_ROWS; r++) begin
        totalRounds += rowRounds[r];
    end
    // Alignment, drain and settling per row on top of the hold time
    #((totalRounds + NUM_ROWS * (DRAIN_ROUNDS + 3) + 4) * ROUND_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired before all rows finished");
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    $display("*** FAILED ***");
    $finish;
end

endmodule

`default_nettype wire

// File: filelist.f
source/emulatorPkg.sv
source/TickDivider.sv
source/IoScanSequencer.sv
source/BoardInputSlot.sv
source/IoEventCollector.sv
source/IoScanner.sv
verif/IoScanner_props.sv
verif/IoScannerTb.sv

// File: Makefile
TOP = IoScannerTb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

build:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
